//--- source/mem_stage_pkg.sv
// widths, AXI IDs and packed bus structs shared by the memory stage
package mem_stage_pkg;

    localparam int DATA_W     = 32;
    localparam int AXI_ID_W   = 4;
    localparam int REG_ADDR_W = 5;
    localparam int STRB_W     = 4;

    // every load goes out with this ID
    localparam logic [AXI_ID_W-1:0] READ_ID = 4'd1;

    // AXI size code for a full word
    localparam logic [2:0] WORD_SIZE = 3'd2;

    // instruction handed over from EXE
    typedef struct packed {
        logic [DATA_W-1:0]     pc;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     store_data;
        logic [STRB_W-1:0]     store_strb;
        logic [2:0]            store_size;
        logic [1:0]            store_byte_offset;
        logic                  mem_en;
        logic                  mem_to_reg;
        logic [3:0]            reg_write;
        logic [REG_ADDR_W-1:0] dest;
        // lb, lbu, lh, lhu, lw
        logic [4:0]            load_kind;
    } exe_mem_bus_t;

    // registered result for WB, load extension happens there
    typedef struct packed {
        logic [DATA_W-1:0]     pc;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     load_data;
        logic [REG_ADDR_W-1:0] dest;
        logic [3:0]            reg_write;
        logic                  mem_to_reg;
        logic [4:0]            load_kind;
    } mem_wb_bus_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [DATA_W-1:0]   addr;
        logic [2:0]          size;
    } axi_ar_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [DATA_W-1:0]   addr;
        logic [2:0]          size;
    } axi_aw_t;

    typedef struct packed {
        logic [AXI_ID_W-1:0] id;
        logic [DATA_W-1:0]   data;
        logic [STRB_W-1:0]   strb;
    } axi_w_t;

endpackage

//--- source/store_tracker.sv
// outstanding write table: free slot selection, release on B, load hazard check
module store_tracker #(
    parameter int STORE_SLOTS = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               alloc,
    input  logic [mem_stage_pkg::DATA_W-1:0]   store_addr,
    input  logic [mem_stage_pkg::DATA_W-1:0]   load_addr,
    input  logic                               bvalid,
    input  logic [mem_stage_pkg::AXI_ID_W-1:0] bid,
    output logic [mem_stage_pkg::AXI_ID_W-1:0] free_id,
    output logic                               slot_free,
    output logic                               read_blocked
);

    localparam int ID_W   = mem_stage_pkg::AXI_ID_W;
    localparam int WORD_W = mem_stage_pkg::DATA_W - 2;

    // one past the last slot means the table is full
    localparam logic [ID_W-1:0] NONE_ID = ID_W'(STORE_SLOTS);

    logic [STORE_SLOTS-1:0] slot_valid;
    logic [STORE_SLOTS-1:0] slot_hit;
    logic [WORD_W-1:0]      slot_word [STORE_SLOTS];
    logic [WORD_W-1:0]      load_word;

    assign load_word = load_addr[mem_stage_pkg::DATA_W-1:2];

    // walk down so the lowest free index is the one left standing
    always_comb begin
        free_id = NONE_ID;
        for (int i = STORE_SLOTS - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_id = ID_W'(i);
            end
        end
    end

    assign slot_free    = !(&slot_valid);
    assign read_blocked = |slot_hit;

    for (genvar i = 0; i < STORE_SLOTS; i++) begin : g_slot
        localparam logic [ID_W-1:0] SLOT_ID = ID_W'(i);

        logic take;
        logic release_slot;

        assign take         = alloc && (free_id == SLOT_ID);
        assign release_slot = bvalid && (bid == SLOT_ID);

        // only whole words are compared, byte lanes do not matter
        assign slot_hit[i] = slot_valid[i] && (slot_word[i] == load_word);

        always_ff @(posedge clk) begin
            if (rst) begin
                slot_valid[i] <= 1'b0;
            end else if (take) begin
                slot_valid[i] <= 1'b1;
            end else if (release_slot) begin
                slot_valid[i] <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (take) begin
                slot_word[i] <= store_addr[mem_stage_pkg::DATA_W-1:2];
            end
        end
    end

endmodule

//--- source/axi_read_master.sv
// AXI AR and R sequencing for a single word load with a held done level
module axi_read_master (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               load_req,
    input  logic                               read_blocked,
    input  logic                               advance,
    input  logic [mem_stage_pkg::DATA_W-1:0]   load_addr,
    input  logic                               arready,
    input  logic                               rvalid,
    input  logic [mem_stage_pkg::AXI_ID_W-1:0] rid,
    input  logic [mem_stage_pkg::DATA_W-1:0]   rdata,
    output mem_stage_pkg::axi_ar_t             ar,
    output logic                               arvalid,
    output logic                               rready,
    output logic                               read_done,
    output logic [mem_stage_pkg::DATA_W-1:0]   read_data
);

    typedef enum logic [1:0] {
        S_WAIT,
        S_ADDR,
        S_DATA,
        S_DONE
    } rd_state_t;

    rd_state_t state;
    logic      r_fire;

    assign r_fire = rvalid && rready && (rid == mem_stage_pkg::READ_ID);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_WAIT;
        end else begin
            case (state)
                // hold off while a pending store covers this word
                S_WAIT: if (load_req && !read_blocked) state <= S_ADDR;
                S_ADDR: if (arready) state <= S_DATA;
                S_DATA: if (r_fire) state <= S_DONE;
                S_DONE: if (advance) state <= S_WAIT;
                default: state <= S_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            read_data <= rdata;
        end
    end

    assign ar.id   = mem_stage_pkg::READ_ID;
    assign ar.addr = {load_addr[mem_stage_pkg::DATA_W-1:2], 2'b00};
    assign ar.size = mem_stage_pkg::WORD_SIZE;

    assign arvalid   = (state == S_ADDR);
    assign rready    = (state == S_DATA);
    assign read_done = (state == S_DONE);

endmodule

//--- source/axi_write_master.sv
// AXI AW and W sequencing for one store, done once both channels are accepted
module axi_write_master (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 store_req,
    input  logic                                 slot_free,
    input  logic [mem_stage_pkg::AXI_ID_W-1:0]   free_id,
    input  logic                                 advance,
    input  logic [mem_stage_pkg::DATA_W-1:0]     store_addr,
    input  logic [mem_stage_pkg::DATA_W-1:0]     store_data,
    input  logic [mem_stage_pkg::STRB_W-1:0]     store_strb,
    input  logic [2:0]                           store_size,
    input  logic [1:0]                           store_byte_offset,
    input  logic                                 awready,
    input  logic                                 wready,
    output mem_stage_pkg::axi_aw_t               aw,
    output logic                                 awvalid,
    output mem_stage_pkg::axi_w_t                w,
    output logic                                 wvalid,
    output logic                                 alloc,
    output logic                                 write_done
);

    logic [mem_stage_pkg::AXI_ID_W-1:0] txn_id;
    logic                               idle;
    logic                               aw_pending;
    logic                               w_pending;

    assign idle  = !awvalid && !wvalid && !write_done;
    assign alloc = idle && store_req && slot_free;

    // still waiting on a channel after this clock
    assign aw_pending = awvalid && !awready;
    assign w_pending  = wvalid && !wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            write_done <= 1'b0;
        end else if (alloc) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            awvalid <= aw_pending;
            wvalid  <= w_pending;
            // both beats may land on the same clock
            if ((awvalid || wvalid) && !aw_pending && !w_pending) begin
                write_done <= 1'b1;
            end else if (advance) begin
                write_done <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            txn_id <= free_id;
        end
    end

    assign aw.id   = txn_id;
    assign aw.addr = {store_addr[mem_stage_pkg::DATA_W-1:2], store_byte_offset};
    assign aw.size = store_size;

    assign w.id   = txn_id;
    assign w.data = store_data;
    assign w.strb = store_strb;

endmodule

//--- source/mem_pipe_ctrl.sv
// stage valid and allowin handshake, memory request classification, MEM/WB register
module mem_pipe_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             exe_to_mem_valid,
    input  mem_stage_pkg::exe_mem_bus_t      exe_bus,
    input  logic                             wb_allowin,
    input  logic                             read_done,
    input  logic                             write_done,
    input  logic [mem_stage_pkg::DATA_W-1:0] read_data,
    output logic                             mem_allowin,
    output logic                             mem_to_wb_valid,
    output mem_stage_pkg::mem_wb_bus_t       mem_wb_bus,
    output logic [mem_stage_pkg::DATA_W-1:0] bypass,
    output logic                             load_req,
    output logic                             store_req,
    output logic                             advance
);

    logic mem_valid;
    logic is_store;
    logic is_load;
    logic ready_go;

    // any byte enable makes it a store, mem_en alone a load
    assign is_store = |exe_bus.store_strb;
    assign is_load  = exe_bus.mem_en && !is_store;

    assign store_req = mem_valid && is_store;
    assign load_req  = mem_valid && is_load;

    // plain ALU ops go through in the cycle they arrive
    always_comb begin
        if (is_store) begin
            ready_go = write_done;
        end else if (is_load) begin
            ready_go = read_done;
        end else begin
            ready_go = 1'b1;
        end
    end

    assign mem_to_wb_valid = mem_valid && ready_go;
    assign mem_allowin     = !mem_valid || (ready_go && wb_allowin);
    assign advance         = mem_to_wb_valid && wb_allowin;

    assign bypass = exe_bus.alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= exe_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb_bus <= '0;
        end else if (advance) begin
            mem_wb_bus.pc         <= exe_bus.pc;
            mem_wb_bus.alu_result <= exe_bus.alu_result;
            // captured word, stale for non-loads and ignored by WB
            mem_wb_bus.load_data  <= read_data;
            mem_wb_bus.dest       <= exe_bus.dest;
            mem_wb_bus.reg_write  <= exe_bus.reg_write;
            mem_wb_bus.mem_to_reg <= exe_bus.mem_to_reg;
            mem_wb_bus.load_kind  <= exe_bus.load_kind;
        end
    end

endmodule

//--- source/mem_stage.sv
// memory stage top level: pipeline control, store tracker, AXI read and write masters
module mem_stage #(
    parameter int STORE_SLOTS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic                                 exe_to_mem_valid,
    input  mem_stage_pkg::exe_mem_bus_t          exe_bus,
    input  logic                                 wb_allowin,
    output logic                                 mem_allowin,
    output logic                                 mem_to_wb_valid,
    output mem_stage_pkg::mem_wb_bus_t           mem_wb_bus,
    output logic [mem_stage_pkg::DATA_W-1:0]     bypass,

    output mem_stage_pkg::axi_ar_t               ar,
    output logic                                 arvalid,
    input  logic                                 arready,
    input  logic [mem_stage_pkg::DATA_W-1:0]     rdata,
    input  logic [mem_stage_pkg::AXI_ID_W-1:0]   rid,
    input  logic                                 rvalid,
    output logic                                 rready,

    output mem_stage_pkg::axi_aw_t               aw,
    output logic                                 awvalid,
    input  logic                                 awready,
    output mem_stage_pkg::axi_w_t                w,
    output logic                                 wvalid,
    input  logic                                 wready,
    input  logic [mem_stage_pkg::AXI_ID_W-1:0]   bid,
    input  logic                                 bvalid,
    output logic                                 bready
);

    logic                               load_req;
    logic                               store_req;
    logic                               advance;
    logic                               read_done;
    logic [mem_stage_pkg::DATA_W-1:0]   read_data;
    logic                               write_done;
    logic [mem_stage_pkg::AXI_ID_W-1:0] free_id;
    logic                               slot_free;
    logic                               read_blocked;
    logic                               alloc;

    // write responses are always taken, the tracker only frees slots
    assign bready = 1'b1;

    mem_pipe_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .exe_to_mem_valid (exe_to_mem_valid),
        .exe_bus          (exe_bus),
        .wb_allowin       (wb_allowin),
        .read_done        (read_done),
        .write_done       (write_done),
        .read_data        (read_data),
        .mem_allowin      (mem_allowin),
        .mem_to_wb_valid  (mem_to_wb_valid),
        .mem_wb_bus       (mem_wb_bus),
        .bypass           (bypass),
        .load_req         (load_req),
        .store_req        (store_req),
        .advance          (advance)
    );

    store_tracker #(
        .STORE_SLOTS (STORE_SLOTS)
    ) u_tracker (
        .clk          (clk),
        .rst          (rst),
        .alloc        (alloc),
        .store_addr   (exe_bus.alu_result),
        .load_addr    (exe_bus.alu_result),
        .bvalid       (bvalid),
        .bid          (bid),
        .free_id      (free_id),
        .slot_free    (slot_free),
        .read_blocked (read_blocked)
    );

    axi_read_master u_rd (
        .clk          (clk),
        .rst          (rst),
        .load_req     (load_req),
        .read_blocked (read_blocked),
        .advance      (advance),
        .load_addr    (exe_bus.alu_result),
        .arready      (arready),
        .rvalid       (rvalid),
        .rid          (rid),
        .rdata        (rdata),
        .ar           (ar),
        .arvalid      (arvalid),
        .rready       (rready),
        .read_done    (read_done),
        .read_data    (read_data)
    );

    axi_write_master u_wr (
        .clk               (clk),
        .rst               (rst),
        .store_req         (store_req),
        .slot_free         (slot_free),
        .free_id           (free_id),
        .advance           (advance),
        .store_addr        (exe_bus.alu_result),
        .store_data        (exe_bus.store_data),
        .store_strb        (exe_bus.store_strb),
        .store_size        (exe_bus.store_size),
        .store_byte_offset (exe_bus.store_byte_offset),
        .awready           (awready),
        .wready            (wready),
        .aw                (aw),
        .awvalid           (awvalid),
        .w                 (w),
        .wvalid            (wvalid),
        .alloc             (alloc),
        .write_done        (write_done)
    );

endmodule

//--- tests/axi_slave_model.sv
// AXI slave with random readies, word memory and out of order write responses
module axi_slave_model (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [31:0]                   rand_bits,
    input  mem_stage_pkg::axi_ar_t        ar,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [31:0]                   rdata,
    output logic [3:0]                    rid,
    output logic                          rvalid,
    input  logic                          rready,
    input  mem_stage_pkg::axi_aw_t        aw,
    input  logic                          awvalid,
    output logic                          awready,
    input  mem_stage_pkg::axi_w_t         w,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [3:0]                    bid,
    output logic                          bvalid,
    input  logic                          bready
);

    localparam logic [31:0] BASE = 32'h0000_1000;

    logic [31:0]            mem [8];
    logic                   rd_busy;
    logic [31:0]            rd_addr;
    logic                   aw_got;
    logic                   w_got;
    mem_stage_pkg::axi_aw_t aw_q;
    mem_stage_pkg::axi_w_t  w_q;
    logic [3:0]             b_q [$];

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
    endfunction

    always @(posedge clk) begin : slave_seq
        mem_stage_pkg::axi_aw_t cur_aw;
        mem_stage_pkg::axi_w_t  cur_w;
        int                     pick;
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rid     <= '0;
            rdata   <= '0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bid     <= '0;
            rd_busy <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_q.delete();
            for (int i = 0; i < 8; i++) begin
                mem[i] <= fill_word(BASE + 32'(i * 4));
            end
        end else begin
            // one read at a time
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_busy <= 1'b1;
                rd_addr <= ar.addr;
            end else begin
                arready <= !rd_busy && rand_bits[0];
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_busy <= 1'b0;
            end else if (rd_busy && !rvalid && rand_bits[1]) begin
                rvalid <= 1'b1;
                rid    <= mem_stage_pkg::READ_ID;
                rdata  <= mem[rd_addr[4:2]];
            end

            // memory takes the write once both AW and W are in
            cur_aw = aw_got ? aw_q : aw;
            cur_w  = w_got ? w_q : w;
            if ((aw_got || (awvalid && awready)) && (w_got || (wvalid && wready))) begin
                for (int b = 0; b < 4; b++) begin
                    if (cur_w.strb[b]) begin
                        mem[cur_aw.addr[4:2]][b*8 +: 8] <= cur_w.data[b*8 +: 8];
                    end
                end
                b_q.push_back(cur_aw.id);
                aw_got  <= 1'b0;
                w_got   <= 1'b0;
                awready <= 1'b0;
                wready  <= 1'b0;
            end else begin
                if (awvalid && awready) begin
                    aw_got  <= 1'b1;
                    aw_q    <= aw;
                    awready <= 1'b0;
                end else begin
                    awready <= !aw_got && rand_bits[2];
                end
                if (wvalid && wready) begin
                    w_got  <= 1'b1;
                    w_q    <= w;
                    wready <= 1'b0;
                end else begin
                    wready <= !w_got && rand_bits[3];
                end
            end

            // responses come back late and in any order
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (!bvalid && b_q.size() > 0 && rand_bits[5:4] == 2'b00) begin
                pick = int'(rand_bits[15:8]) % b_q.size();
                bid  <= b_q[pick];
                b_q.delete(pick);
                bvalid <= 1'b1;
            end
        end
    end

endmodule

//--- tests/mem_stage_properties.sv
// handshake stability, read ID, load hazard and reset rules for mem_stage
module mem_stage_properties (
    input logic                   clk,
    input logic                   rst,
    input mem_stage_pkg::axi_ar_t ar,
    input logic                   arvalid,
    input logic                   arready,
    input logic                   rready,
    input mem_stage_pkg::axi_aw_t aw,
    input logic                   awvalid,
    input logic                   awready,
    input logic                   wvalid,
    input logic                   wready,
    input logic [3:0]             bid,
    input logic                   bvalid,
    input logic                   bready,
    input logic                   mem_to_wb_valid
);

    // word address per write ID between AW acceptance and its B beat
    logic [29:0] out_word [16];
    logic [15:0] out_live;
    logic [15:0] word_hit;

    always @(posedge clk) begin
        if (rst) begin
            out_live <= '0;
        end else begin
            if (bvalid && bready) begin
                out_live[bid] <= 1'b0;
            end
            if (awvalid && awready) begin
                out_live[aw.id] <= 1'b1;
                out_word[aw.id] <= aw.addr[31:2];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            word_hit[i] = out_live[i] && (out_word[i] == ar.addr[31:2]);
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before its handshake");
    aw_hold: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before its handshake");
    w_hold: assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before its handshake");

    ar_id: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> ar.id == mem_stage_pkg::READ_ID)
        else $error("read issued with a wrong ID");

    // a load must never pass a store to the same word
    ar_hazard: assert property (@(posedge clk) disable iff (rst)
        arvalid && arready |-> !(|word_hit))
        else $error("read accepted while a store to the same word is outstanding");

    reset_quiet: assert property (@(posedge clk)
        rst |=> !arvalid && !rready && !awvalid && !wvalid && !mem_to_wb_valid)
        else $error("valid output high after reset");

endmodule

bind mem_stage mem_stage_properties props0 (
    .clk             (clk),
    .rst             (rst),
    .ar              (ar),
    .arvalid         (arvalid),
    .arready         (arready),
    .rready          (rready),
    .aw              (aw),
    .awvalid         (awvalid),
    .awready         (awready),
    .wvalid          (wvalid),
    .wready          (wready),
    .bid             (bid),
    .bvalid          (bvalid),
    .bready          (bready),
    .mem_to_wb_valid (mem_to_wb_valid)
);

//--- tests/tb_mem_stage.sv
// mem_stage testbench with random instruction stream, memory model, checks and watchdog
module tb_mem_stage;

    localparam int          NUM_INSTR   = 400;
    localparam int          STORE_SLOTS = 4;
    localparam logic [31:0] BASE        = 32'h0000_1000;

    logic                         clk = 1'b0;
    logic                         rst;
    integer                       seed = 32'h6706_75ef;
    logic [31:0]                  rand_bits;
    logic                         exe_to_mem_valid;
    mem_stage_pkg::exe_mem_bus_t  exe_bus;
    logic                         wb_allowin;
    logic                         mem_allowin;
    logic                         mem_to_wb_valid;
    mem_stage_pkg::mem_wb_bus_t   mem_wb_bus;
    logic [31:0]                  bypass;
    mem_stage_pkg::axi_ar_t       ar;
    logic                         arvalid;
    logic                         arready;
    logic [31:0]                  rdata;
    logic [3:0]                   rid;
    logic                         rvalid;
    logic                         rready;
    mem_stage_pkg::axi_aw_t       aw;
    logic                         awvalid;
    logic                         awready;
    mem_stage_pkg::axi_w_t        w;
    logic                         wvalid;
    logic                         wready;
    logic [3:0]                   bid;
    logic                         bvalid;
    logic                         bready;

    logic [31:0]                  model [8];
    logic                         id_busy [16];
    mem_stage_pkg::mem_wb_bus_t   exp_q [$];
    logic                         load_q [$];
    int                           received = 0;
    logic                         aw_seen;
    logic                         w_seen;
    logic [3:0]                   aw_seen_id;
    logic [3:0]                   w_seen_id;

    mem_stage #(.STORE_SLOTS(STORE_SLOTS)) dut0 (.*);
    axi_slave_model slave0 (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_5a5a;
    endfunction

    task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // next instruction in program order and its expected WB result
    task automatic make_instr(output mem_stage_pkg::exe_mem_bus_t ins);
        mem_stage_pkg::mem_wb_bus_t exp;
        int                         kind;
        int                         idx;
        kind = int'({$random(seed)} % 3);
        idx  = int'({$random(seed)} % 8);
        ins = '0;
        ins.pc = $random(seed);
        ins.dest = 5'($random(seed));
        ins.alu_result = BASE + 32'(idx * 4);
        if (kind == 0) begin
            ins.alu_result = $random(seed);
            ins.reg_write = 4'hf;
        end else if (kind == 1) begin
            ins.mem_en = 1'b1;
            ins.mem_to_reg = 1'b1;
            ins.reg_write = 4'hf;
            ins.load_kind = 5'b00001 << ({$random(seed)} % 5);
            ins.alu_result[1:0] = 2'($random(seed));
        end else begin
            ins.mem_en = 1'b1;
            ins.store_data = $random(seed);
            ins.store_strb = 4'({$random(seed)} % 15 + 1);
            ins.store_size = mem_stage_pkg::WORD_SIZE;
        end
        exp = '0;
        exp.pc = ins.pc;
        exp.alu_result = ins.alu_result;
        exp.load_data = model[idx];
        exp.dest = ins.dest;
        exp.reg_write = ins.reg_write;
        exp.mem_to_reg = ins.mem_to_reg;
        exp.load_kind = ins.load_kind;
        for (int b = 0; b < 4; b++) begin
            if (ins.store_strb[b]) begin
                model[idx][b*8 +: 8] = ins.store_data[b*8 +: 8];
            end
        end
        exp_q.push_back(exp);
        load_q.push_back(kind == 1);
    endtask

    // returns just after the first clock edge that saw mem_allowin high
    task automatic wait_allowin();
        logic hit;
        hit = 1'b0;
        while (!hit) begin
            @(negedge clk);
            hit = mem_allowin;
            @(posedge clk);
            #10;
        end
    endtask

    task automatic run_stream();
        mem_stage_pkg::exe_mem_bus_t ins;
        logic                        in_mem;
        in_mem = 1'b0;
        for (int k = 0; k < NUM_INSTR; k++) begin
            make_instr(ins);
            exe_bus = ins;
            if (!in_mem) begin
                exe_to_mem_valid = 1'b1;
                wait_allowin();
            end
            // exe_bus holds until this one leaves and a bubble follows now and then
            exe_to_mem_valid = (k < NUM_INSTR - 1) && (($random(seed) % 8) != 0);
            wait_allowin();
            in_mem = exe_to_mem_valid;
        end
    endtask

    task automatic compare_out();
        mem_stage_pkg::mem_wb_bus_t exp;
        logic                       is_load;
        if (exp_q.size() == 0) begin
            $display("an instruction reached WB that was never sent");
            $display("Simulation FAILED");
            $fatal(1, "extra instruction");
        end else begin
            exp = exp_q.pop_front();
            is_load = load_q.pop_front();
            check("wb pc", exp.pc, mem_wb_bus.pc);
            check("wb alu_result", exp.alu_result, mem_wb_bus.alu_result);
            check("wb dest", 32'(exp.dest), 32'(mem_wb_bus.dest));
            check("wb reg_write", 32'(exp.reg_write), 32'(mem_wb_bus.reg_write));
            check("wb mem_to_reg", 32'(exp.mem_to_reg), 32'(mem_wb_bus.mem_to_reg));
            check("wb load_kind", 32'(exp.load_kind), 32'(mem_wb_bus.load_kind));
            if (is_load) begin
                check("load data", exp.load_data, mem_wb_bus.load_data);
            end
            received++;
        end
    endtask

    always @(posedge clk) begin
        #10;
        rand_bits = $random(seed);
        if (!rst) begin
            wb_allowin = ($random(seed) % 4) != 0;
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            check("bypass", exe_bus.alu_result, bypass);
            if (bvalid && bready) begin
                id_busy[bid] = 1'b0;
            end
            if (arvalid && arready) begin
                check("ar addr", exe_bus.alu_result & ~32'h3, ar.addr);
                check("ar size", 32'd2, 32'(ar.size));
            end
            if (awvalid && awready) begin
                // stores in this stream are word aligned with a zero byte offset
                check("aw addr", exe_bus.alu_result, aw.addr);
                check("aw size", 32'(exe_bus.store_size), 32'(aw.size));
                check("awid in range", 32'd1, 32'(aw.id < STORE_SLOTS));
                check("awid not in use", 32'd0, 32'(id_busy[aw.id]));
                id_busy[aw.id] = 1'b1;
                aw_seen_id = aw.id;
                aw_seen = 1'b1;
            end
            if (wvalid && wready) begin
                check("w data", exe_bus.store_data, w.data);
                check("w strb", 32'(exe_bus.store_strb), 32'(w.strb));
                w_seen_id = w.id;
                w_seen = 1'b1;
            end
            if (aw_seen && w_seen) begin
                check("wid matches awid", 32'(aw_seen_id), 32'(w_seen_id));
                aw_seen = 1'b0;
                w_seen = 1'b0;
            end
            if (mem_to_wb_valid && wb_allowin) begin
                @(posedge clk);
                #1;
                compare_out();
            end
        end
    end

    initial begin
        rst = 1'b1;
        exe_to_mem_valid = 1'b0;
        exe_bus = '0;
        wb_allowin = 1'b0;
        rand_bits = '0;
        aw_seen = 1'b0;
        w_seen = 1'b0;
        for (int i = 0; i < 16; i++) begin
            id_busy[i] = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin
            model[i] = fill_word(BASE + 32'(i * 4));
        end
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
        run_stream();
        repeat (4) @(posedge clk);
        if (received == NUM_INSTR && exp_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d instructions reached WB", received, NUM_INSTR);
            $display("Simulation FAILED");
            $fatal(1, "instructions lost");
        end
    end

    // watchdog allows 40 cycles per instruction plus reset
    initial begin
        #(100 * (NUM_INSTR * 40 + 10));
        $display("timeout: the instruction stream did not drain in time");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

endmodule

//--- all.f
source/mem_stage_pkg.sv
source/store_tracker.sv
source/axi_read_master.sv
source/axi_write_master.sv
source/mem_pipe_ctrl.sv
source/mem_stage.sv
tests/axi_slave_model.sv
tests/mem_stage_properties.sv
tests/tb_mem_stage.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f all.f --top-module tb_mem_stage > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_mem_stage > sim.log 2>&1
grep -q "Simulation FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "simulation passed"
